/* hw/spi_clk_gen.sv */
// SPI baud divider, SCK generation and parking, bit boundary and sample pulses
`timescale 1ns/1ps

module spi_clk_gen #(
   parameter int                           DATA_W    = spi_pkg::DATA_W,
   parameter logic [spi_pkg::ADR_W-1:0]    SPCR_ADDR = spi_pkg::SPCR_ADDR
) (
   input  logic                            cp2,
   input  logic                            ireset,
   input  logic [spi_pkg::ADR_W-1:0]       adr,
   input  logic [DATA_W-1:0]               dbus_in,
   input  logic                            iowe,
   spi_ctrl_if.clk                         ctrl,
   output logic                            scko,
   output logic                            bit_end,
   output logic                            sample
);

   logic [spi_pkg::DIV_W-1:0] div_cnt;
   logic [spi_pkg::DIV_W-1:0] div_last;          // Terminal count of a half period
   int unsigned               hp_m1;
   logic                      phase;             // 0 first half, 1 second half of a bit
   logic                      toggle;
   logic                      spcr_wr;

   always_comb
   begin
      hp_m1    = spi_pkg::half_period({ctrl.spi2x, ctrl.spr}) - 1;
      div_last = hp_m1[spi_pkg::DIV_W-1:0];
   end

   assign toggle  = ctrl.busy && (div_cnt == div_last);
   assign bit_end = toggle && phase;
   assign spcr_wr = iowe && (adr == SPCR_ADDR);

   // ******************************
   // Divider, runs only while busy
   // ******************************
   always_ff @(posedge cp2)
   begin
      if (!ireset || !ctrl.busy)
      begin
         div_cnt <= '0;
         phase   <= 1'b0;
      end
      else if (toggle)
      begin
         div_cnt <= '0;
         phase   <= ~phase;
      end
      else
         div_cnt <= div_cnt + 1'b1;
   end

   // SCK output
   always_ff @(posedge cp2)
   begin
      if (!ireset)
         scko <= 1'b0;
      else if (spcr_wr)
         scko <= dbus_in[spi_pkg::CPOL_BIT];     // Idle level follows new CPOL
      else if (ctrl.start && ctrl.cpha)
         scko <= ~ctrl.cpol;                     // Leading edge in CPHA 1
      else if (ctrl.done)
         scko <= ctrl.cpol;                      // Park
      else if (toggle)
         scko <= ~scko;
   end

   // Sampling edge ends the first half of each bit for every CPOL/CPHA mode
   always_ff @(posedge cp2)
   begin
      if (!ireset)
         sample <= 1'b0;
      else
         sample <= toggle && !phase;
   end

endmodule

/* hw/spi_ctrl_if.sv */
// Configuration and transfer control between SPI register block and engine
`timescale 1ns/1ps

interface spi_ctrl_if #(
   parameter int DATA_W = spi_pkg::DATA_W
) ();

   // Configuration from SPCR/SPSR
   logic              spe;
   logic              mstr;
   logic              dord;
   logic              cpol;
   logic              cpha;
   logic [1:0]        spr;
   logic              spi2x;

   // Transfer control
   logic [DATA_W-1:0] tx_data;
   logic              start;                     // One cycle, SPDR write accepted
   logic              busy;
   logic              done;                      // Last bit boundary
   logic [DATA_W-1:0] rx_data;

   modport regs (
      output spe, mstr, dord, cpol, cpha, spr, spi2x, tx_data, start,
      input  busy, done, rx_data
   );

   modport clk (
      input cpol, cpha, spr, spi2x, start, busy, done
   );

   modport engine (
      input  dord, tx_data, start,
      output busy, done, rx_data
   );

endinterface

/* hw/spi_mod.sv */
// SPI master peripheral top level with register block, clock generator and shifter
`timescale 1ns/1ps

module spi_mod #(
   parameter int                           DATA_W    = spi_pkg::DATA_W,
   parameter logic [spi_pkg::ADR_W-1:0]    SPCR_ADDR = spi_pkg::SPCR_ADDR,
   parameter logic [spi_pkg::ADR_W-1:0]    SPSR_ADDR = spi_pkg::SPSR_ADDR,
   parameter logic [spi_pkg::ADR_W-1:0]    SPDR_ADDR = spi_pkg::SPDR_ADDR
) (
   input  logic                            cp2,
   input  logic                            ireset,
   // CPU I/O bus
   input  logic [spi_pkg::ADR_W-1:0]       adr,
   input  logic [DATA_W-1:0]               dbus_in,
   input  logic                            iore,
   input  logic                            iowe,
   output logic [DATA_W-1:0]               dbus_out,
   output logic                            out_en,
   // SPI pins
   input  logic                            misoi,
   output logic                            mosio,
   output logic                            scko,
   output logic                            spe,
   output logic                            spimaster,
   // Interrupt
   output logic                            spiirq,
   input  logic                            spiack
);

   logic bit_end;
   logic sample;

   spi_ctrl_if #(.DATA_W(DATA_W)) ctrl_bus ();

   spi_regs #(
      .DATA_W    (DATA_W),
      .SPCR_ADDR (SPCR_ADDR),
      .SPSR_ADDR (SPSR_ADDR),
      .SPDR_ADDR (SPDR_ADDR)
   ) i_spi_regs (
      .cp2       (cp2),
      .ireset    (ireset),
      .adr       (adr),
      .dbus_in   (dbus_in),
      .iore      (iore),
      .iowe      (iowe),
      .spiack    (spiack),
      .dbus_out  (dbus_out),
      .out_en    (out_en),
      .spe       (spe),
      .spimaster (spimaster),
      .spiirq    (spiirq),
      .ctrl      (ctrl_bus.regs)
   );

   spi_clk_gen #(
      .DATA_W    (DATA_W),
      .SPCR_ADDR (SPCR_ADDR)
   ) i_spi_clk_gen (
      .cp2     (cp2),
      .ireset  (ireset),
      .adr     (adr),
      .dbus_in (dbus_in),
      .iowe    (iowe),
      .ctrl    (ctrl_bus.clk),
      .scko    (scko),
      .bit_end (bit_end),
      .sample  (sample)
   );

   spi_shifter #(
      .DATA_W (DATA_W)
   ) i_spi_shifter (
      .cp2     (cp2),
      .ireset  (ireset),
      .misoi   (misoi),
      .bit_end (bit_end),
      .sample  (sample),
      .ctrl    (ctrl_bus.engine),
      .mosio   (mosio)
   );

endmodule

/* hw/spi_pkg.sv */
// SPI register map, SPCR/SPSR bit positions, SCK divider table and bit reversal
package spi_pkg;

   localparam int ADR_W  = 6;
   localparam int DATA_W = 8;
   localparam int DIV_W  = 6;                    // Divider counter, up to 64 cycles

   localparam logic [ADR_W-1:0] SPCR_ADDR = 6'h0D;
   localparam logic [ADR_W-1:0] SPSR_ADDR = 6'h0E;
   localparam logic [ADR_W-1:0] SPDR_ADDR = 6'h0F;

   // SPCR fields
   localparam int SPIE_BIT = 7;
   localparam int SPE_BIT  = 6;
   localparam int DORD_BIT = 5;
   localparam int MSTR_BIT = 4;
   localparam int CPOL_BIT = 3;
   localparam int CPHA_BIT = 2;
   localparam int SPR_LSB  = 0;                  // SPR is two bits wide

   // SPSR fields
   localparam int SPIF_BIT  = 7;
   localparam int WCOL_BIT  = 6;
   localparam int SPI2X_BIT = 0;

   // cp2 cycles per half SCK period, rate code is {SPI2X, SPR}
   function automatic int unsigned half_period(input logic [2:0] rate);
      case (rate)
         3'b000:  return 2;
         3'b001:  return 8;
         3'b010:  return 32;
         3'b011:  return 64;
         3'b100:  return 1;
         3'b101:  return 4;
         3'b110:  return 16;
         default: return 32;
      endcase
   endfunction

   function automatic logic [DATA_W-1:0] rev_bits(input logic [DATA_W-1:0] d);
      logic [DATA_W-1:0] r;
      for (int i = 0; i < DATA_W; i++)
         r[i] = d[DATA_W-1-i];
      return r;
   endfunction

endpackage

/* hw/spi_regs.sv */
// SPI control/status registers, SPIF and WCOL flags, transfer start and read mux
`timescale 1ns/1ps

module spi_regs #(
   parameter int                           DATA_W    = spi_pkg::DATA_W,
   parameter logic [spi_pkg::ADR_W-1:0]    SPCR_ADDR = spi_pkg::SPCR_ADDR,
   parameter logic [spi_pkg::ADR_W-1:0]    SPSR_ADDR = spi_pkg::SPSR_ADDR,
   parameter logic [spi_pkg::ADR_W-1:0]    SPDR_ADDR = spi_pkg::SPDR_ADDR
) (
   input  logic                            cp2,
   input  logic                            ireset,
   input  logic [spi_pkg::ADR_W-1:0]       adr,
   input  logic [DATA_W-1:0]               dbus_in,
   input  logic                            iore,
   input  logic                            iowe,
   input  logic                            spiack,
   output logic [DATA_W-1:0]               dbus_out,
   output logic                            out_en,
   output logic                            spe,
   output logic                            spimaster,
   output logic                            spiirq,
   spi_ctrl_if.regs                        ctrl
);

   logic [DATA_W-1:0] spcr;
   logic              spi2x;
   logic              spif;
   logic              wcol;
   logic              spif_clr_st;               // SPSR read with SPIF set
   logic              wcol_clr_st;               // SPSR read with WCOL set
   logic [DATA_W-1:0] spsr_val;

   logic              spcr_wr;
   logic              spsr_wr;
   logic              spdr_wr;
   logic              spsr_rd;
   logic              spdr_acc;
   logic              collision;

   // ******************************
   // Bus decode
   // ******************************
   assign spcr_wr   = iowe && (adr == SPCR_ADDR);
   assign spsr_wr   = iowe && (adr == SPSR_ADDR);
   assign spdr_wr   = iowe && (adr == SPDR_ADDR);
   assign spsr_rd   = iore && (adr == SPSR_ADDR);
   assign spdr_acc  = (iore || iowe) && (adr == SPDR_ADDR);
   assign collision = spdr_wr && ctrl.busy;      // Dropped write

   assign ctrl.start = spdr_wr && spcr[spi_pkg::SPE_BIT] && spcr[spi_pkg::MSTR_BIT] &&
                       !ctrl.busy;
   assign ctrl.tx_data = dbus_in;

   always_ff @(posedge cp2)
   begin
      if (!ireset)
      begin
         spcr  <= '0;
         spi2x <= 1'b0;
      end
      else
      begin
         if (spcr_wr)
            spcr <= dbus_in;
         if (spsr_wr)
            spi2x <= dbus_in[spi_pkg::SPI2X_BIT];  // Only writable SPSR bit
      end
   end

   // ******************************
   // Flags and clear sequences
   // ******************************
   always_ff @(posedge cp2)
   begin
      if (!ireset)
      begin
         spif        <= 1'b0;
         wcol        <= 1'b0;
         spif_clr_st <= 1'b0;
         wcol_clr_st <= 1'b0;
      end
      else
      begin
         if (!spif_clr_st)
            spif_clr_st <= spsr_rd && spif;
         else if (spdr_acc)
            spif_clr_st <= 1'b0;

         if (!wcol_clr_st)
            wcol_clr_st <= spsr_rd && wcol;
         else if (spdr_acc)
            wcol_clr_st <= 1'b0;

         if (ctrl.done)
            spif <= 1'b1;
         else if ((spdr_acc && spif_clr_st) || spiack)
            spif <= 1'b0;

         if (collision)
            wcol <= 1'b1;                        // Set wins over the clearing access
         else if (spdr_acc && wcol_clr_st)
            wcol <= 1'b0;
      end
   end

   // Configuration to clock generator and shifter
   assign ctrl.spe   = spcr[spi_pkg::SPE_BIT];
   assign ctrl.mstr  = spcr[spi_pkg::MSTR_BIT];
   assign ctrl.dord  = spcr[spi_pkg::DORD_BIT];
   assign ctrl.cpol  = spcr[spi_pkg::CPOL_BIT];
   assign ctrl.cpha  = spcr[spi_pkg::CPHA_BIT];
   assign ctrl.spr   = spcr[spi_pkg::SPR_LSB +: 2];
   assign ctrl.spi2x = spi2x;

   assign spe       = ctrl.spe;
   assign spimaster = ctrl.mstr;
   assign spiirq    = spcr[spi_pkg::SPIE_BIT] && spif;

   always_comb
   begin
      spsr_val                     = '0;
      spsr_val[spi_pkg::SPIF_BIT]  = spif;
      spsr_val[spi_pkg::WCOL_BIT]  = wcol;
      spsr_val[spi_pkg::SPI2X_BIT] = spi2x;
   end

   // Read mux, combinational on adr and iore
   always_comb
   begin
      dbus_out = '0;
      out_en   = 1'b0;
      case (adr)
         SPDR_ADDR:
         begin
            dbus_out = ctrl.rx_data;
            out_en   = iore;
         end
         SPSR_ADDR:
         begin
            dbus_out = spsr_val;
            out_en   = iore;
         end
         SPCR_ADDR:
         begin
            dbus_out = spcr;
            out_en   = iore;
         end
         default: ;
      endcase
   end

endmodule

/* hw/spi_shifter.sv */
// SPI master bit FSM, shift register, MISO sampling and receive register
`timescale 1ns/1ps

module spi_shifter #(
   parameter int DATA_W = spi_pkg::DATA_W
) (
   input  logic        cp2,
   input  logic        ireset,
   input  logic        misoi,
   input  logic        bit_end,
   input  logic        sample,
   spi_ctrl_if.engine  ctrl,
   output logic        mosio
);

   typedef enum logic [3:0] {
      ST_IDLE,
      ST_B0,
      ST_B1,
      ST_B2,
      ST_B3,
      ST_B4,
      ST_B5,
      ST_B6,
      ST_B7
   } bit_state_t;

   bit_state_t        state;
   logic [DATA_W-1:0] sh_reg;
   logic [DATA_W-1:0] sh_next;
   logic [DATA_W-1:0] tx_word;
   logic [DATA_W-1:0] rx_reg;
   logic              rx_bit;                    // MISO held from the sampling edge
   logic              shift_in;
   logic              upd_rx;

   // ******************************
   // Bit state machine
   // ******************************
   always_ff @(posedge cp2)
   begin
      if (!ireset)
         state <= ST_IDLE;
      else if (state == ST_IDLE)
      begin
         if (ctrl.start)
            state <= ST_B0;
      end
      else if (bit_end)
      begin
         if (state == ST_B7)
            state <= ST_IDLE;
         else
            state <= bit_state_t'(state + 4'd1);
      end
   end

   assign ctrl.busy = (state != ST_IDLE);
   assign ctrl.done = (state == ST_B7) && bit_end;

   // ******************************
   // Data path
   // ******************************
   always_ff @(posedge cp2)
   begin
      if (sample)
         rx_bit <= misoi;
   end

   // At the fastest rate sample and bit_end fall in the same cycle
   assign shift_in = sample ? misoi : rx_bit;
   assign sh_next  = {sh_reg[DATA_W-2:0], shift_in};
   assign tx_word  = ctrl.dord ? spi_pkg::rev_bits(ctrl.tx_data) : ctrl.tx_data;

   always_ff @(posedge cp2)
   begin
      if (!ireset)
      begin
         sh_reg <= '1;
         rx_reg <= '0;
         upd_rx <= 1'b0;
      end
      else
      begin
         upd_rx <= ctrl.done;
         if (ctrl.start)
            sh_reg <= tx_word;                   // LSB first goes out reversed
         else if (bit_end)
            sh_reg <= sh_next;
         else if (upd_rx)
            sh_reg[DATA_W-1] <= 1'b1;

         if (ctrl.done)
            rx_reg <= ctrl.dord ? spi_pkg::rev_bits(sh_next) : sh_next;
      end
   end

   assign ctrl.rx_data = rx_reg;

   // Line idles low between transfers
   assign mosio = ctrl.busy && sh_reg[DATA_W-1];

endmodule

/* run.sh */
#!/usr/bin/env bash
# Build the SPI testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal --top-module tb_spi_mod \
   --Mdir obj_dir -o vsim -f spi_mod.f \
   && ./obj_dir/vsim | tee /dev/stderr | grep -x "Simulation completed successfully" > /dev/null \
   && echo "PASS" \
   || { echo "FAIL"; exit 1; }

/* sim/spi_mod_asserts.sv */
// Bound SPI checks on interrupt output, read enable and idle SCK level
`timescale 1ns/1ps

module spi_mod_asserts (
   input logic                         cp2,
   input logic                         ireset,
   input logic [spi_pkg::ADR_W-1:0]    adr,
   input logic [spi_pkg::DATA_W-1:0]   dbus_in,
   input logic [spi_pkg::DATA_W-1:0]   dbus_out,
   input logic                         iore,
   input logic                         iowe,
   input logic                         out_en,
   input logic                         scko,
   input logic                         spiirq,
   input logic                         busy
);

   int   fail_cnt = 0;                           // Read by the testbench at the end
   logic spie_seen;                              // SPIE as last written on the bus

   always_ff @(posedge cp2)
   begin
      if (!ireset)
         spie_seen <= 1'b0;
      else if (iowe && (adr == spi_pkg::SPCR_ADDR))
         spie_seen <= dbus_in[spi_pkg::SPIE_BIT];
   end

   // Interrupt is SPIF gated by SPIE, seen on each SPSR read
   irq_follows_flag: assert property (@(posedge cp2) disable iff (!ireset)
      (out_en && (adr == spi_pkg::SPSR_ADDR)) |->
      (spiirq == (spie_seen && dbus_out[spi_pkg::SPIF_BIT])))
   else
   begin
      $error("spiirq does not match SPIE and SPIF");
      fail_cnt++;
   end

   read_enable_only_on_read: assert property (@(posedge cp2) disable iff (!ireset)
      out_en |-> iore)
   else
   begin
      $error("out_en high without iore");
      fail_cnt++;
   end

   // No engine activity and no SPCR write, so SCK must not move
   scko_idle_stable: assert property (@(posedge cp2) disable iff (!ireset)
      (!$past(busy) && !$past(iowe)) |-> $stable(scko))
   else
   begin
      $error("scko changed while no transfer was running");
      fail_cnt++;
   end

endmodule

/* sim/tb_spi_mod.sv */
// SPI master testbench with bus tasks, slave model, reference function and checker
`timescale 1ns/1ps

module tb_spi_mod;

   localparam int     NUM_XFERS   = 18;
   localparam int     POLL_LIMIT  = 16 * 64 + 32;
   localparam longint WATCHDOG_NS = (NUM_XFERS * 16 * 64 + 4000) * 10;

   logic                      cp2;
   logic                      ireset;
   logic [spi_pkg::ADR_W-1:0] adr;
   logic [7:0]                dbus_in;
   logic                      iore;
   logic                      iowe;
   logic [7:0]                dbus_out;
   logic                      out_en;
   logic                      misoi;
   logic                      mosio;
   logic                      scko;
   logic                      spe;
   logic                      spimaster;
   logic                      spiirq;
   logic                      spiack;

   // Slave model state
   logic       xfer_on;
   logic       cur_cpol;
   logic       cur_cpha;
   logic [2:0] cur_rate;
   logic [7:0] slv_byte;
   logic [7:0] slv_wire;                         // Slave byte in wire order
   logic [7:0] slv_rec;
   int         n_samp;
   int         edge_cnt;
   time        last_edge_t;

   // Pending checks
   string chk_name_q[$];
   int    chk_exp_q[$];
   int    chk_act_q[$];
   time   chk_time_q[$];

   spi_mod i_spi_mod (
      .cp2       (cp2),
      .ireset    (ireset),
      .adr       (adr),
      .dbus_in   (dbus_in),
      .iore      (iore),
      .iowe      (iowe),
      .dbus_out  (dbus_out),
      .out_en    (out_en),
      .misoi     (misoi),
      .mosio     (mosio),
      .scko      (scko),
      .spe       (spe),
      .spimaster (spimaster),
      .spiirq    (spiirq),
      .spiack    (spiack)
   );

   bind spi_mod spi_mod_asserts i_spi_mod_asserts (
      .cp2      (cp2),
      .ireset   (ireset),
      .adr      (adr),
      .dbus_in  (dbus_in),
      .dbus_out (dbus_out),
      .iore     (iore),
      .iowe     (iowe),
      .out_en   (out_en),
      .scko     (scko),
      .spiirq   (spiirq),
      .busy     (ctrl_bus.busy)
   );

   initial cp2 = 1'b0;
   always #5 cp2 = ~cp2;

   // ******************************
   // Helpers
   // ******************************
   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Simulation failed");
      $fatal(1, "Run stopped");
   endtask

   task automatic check_val(input string name, input int exp, input int act);
      chk_name_q.push_back(name);
      chk_exp_q.push_back(exp);
      chk_act_q.push_back(act);
      chk_time_q.push_back($time);
   endtask

   task automatic bus_write(input logic [spi_pkg::ADR_W-1:0] a, input logic [7:0] d);
      adr     = a;
      dbus_in = d;
      iowe    = 1'b1;
      @(posedge cp2);
      #1;
      iowe    = 1'b0;
   endtask

   task automatic bus_read(input logic [spi_pkg::ADR_W-1:0] a, output logic [7:0] d);
      adr  = a;
      iore = 1'b1;
      #4;                                        // Mid cycle, read path is combinational
      d    = dbus_out;
      check_val("out_en", 1, out_en);
      @(posedge cp2);
      #1;
      iore = 1'b0;
   endtask

   // Slave records the written byte in wire order, master gets the slave byte back
   function automatic logic [15:0] expected_words(input logic [7:0] tx, input logic [7:0] slv,
                                                  input logic dord);
      logic [7:0] on_wire;
      on_wire = dord ? spi_pkg::rev_bits(tx) : tx;
      return {on_wire, slv};
   endfunction

   // ******************************
   // Slave model
   // ******************************
   always @(scko)
   begin
      #1;
      if (xfer_on)
      begin
         if (edge_cnt > 0)
            check_val("scko half period", spi_pkg::half_period(cur_rate),
                      int'(($time - last_edge_t) / 10));
         last_edge_t = $time;
         edge_cnt++;
         if (scko == (cur_cpol == cur_cpha))     // Sampling edge
         begin
            slv_rec = {slv_rec[6:0], mosio};
            n_samp++;
         end
         else if (n_samp < 8)
            misoi = slv_wire[7 - n_samp];
      end
   end

   // One transfer with clear by SPSR/SPDR, optional spiack clear or write collision
   task automatic run_transfer(input logic [2:0] mode, input logic [2:0] rate,
                               input logic spie_en, input logic [7:0] tx,
                               input logic collide, input logic use_ack);
      logic [7:0]  spcr_val;
      logic [7:0]  spsr_val;
      logic [7:0]  sr;
      logic [7:0]  rd;
      logic [15:0] exp_w;
      int          polls;
      spcr_val                          = '0;
      spcr_val[spi_pkg::SPIE_BIT]       = spie_en;
      spcr_val[spi_pkg::SPE_BIT]        = 1'b1;
      spcr_val[spi_pkg::MSTR_BIT]       = 1'b1;
      spcr_val[spi_pkg::CPOL_BIT]       = mode[2];
      spcr_val[spi_pkg::CPHA_BIT]       = mode[1];
      spcr_val[spi_pkg::DORD_BIT]       = mode[0];
      spcr_val[spi_pkg::SPR_LSB +: 2]   = rate[1:0];
      spsr_val                          = '0;
      spsr_val[spi_pkg::SPI2X_BIT]      = rate[2];
      bus_write(spi_pkg::SPSR_ADDR, spsr_val);
      bus_write(spi_pkg::SPCR_ADDR, spcr_val);
      bus_read(spi_pkg::SPCR_ADDR, rd);
      check_val("SPCR", spcr_val, rd);
      check_val("scko idle", mode[2], scko);
      check_val("spe", 1, spe);
      check_val("spimaster", 1, spimaster);

      cur_cpol = mode[2];
      cur_cpha = mode[1];
      cur_rate = rate;
      slv_byte = 8'($urandom);
      slv_wire = mode[0] ? spi_pkg::rev_bits(slv_byte) : slv_byte;
      slv_rec  = '0;
      n_samp   = 0;
      edge_cnt = 0;
      misoi    = slv_wire[7];                    // First bit ready before any edge
      xfer_on  = 1'b1;

      bus_write(spi_pkg::SPDR_ADDR, tx);
      if (collide)
         bus_write(spi_pkg::SPDR_ADDR, ~tx);

      sr    = '0;
      polls = 0;
      while (!sr[spi_pkg::SPIF_BIT] && polls < POLL_LIMIT)
      begin
         bus_read(spi_pkg::SPSR_ADDR, sr);
         polls++;
      end
      check_val("SPSR SPIF", 1, sr[spi_pkg::SPIF_BIT]);
      check_val("SPSR WCOL", collide, sr[spi_pkg::WCOL_BIT]);
      check_val("spiirq", spie_en, spiirq);

      exp_w = expected_words(tx, slv_byte, mode[0]);
      check_val("slave mosio byte", exp_w[15:8], slv_rec);
      check_val("slave sample count", 8, n_samp);
      check_val("scko edge count", 16, edge_cnt);
      check_val("scko parked", mode[2], scko);
      xfer_on = 1'b0;

      if (use_ack)
      begin
         spiack = 1'b1;
         @(posedge cp2);
         #1;
         spiack = 1'b0;
         bus_read(spi_pkg::SPSR_ADDR, sr);
         check_val("SPSR SPIF after spiack", 0, sr[spi_pkg::SPIF_BIT]);
         check_val("spiirq after spiack", 0, spiirq);
      end

      bus_read(spi_pkg::SPDR_ADDR, rd);
      check_val("SPDR", exp_w[7:0], rd);
      bus_read(spi_pkg::SPSR_ADDR, sr);
      check_val("SPSR after clear", spsr_val, sr);   // SPIF and WCOL both gone
      check_val("spiirq after clear", 0, spiirq);
   endtask

   // ******************************
   // Comparison and watchdog
   // ******************************
   always @(negedge cp2)
   begin
      string nm;
      int    e;
      int    a;
      time   t;
      while (chk_act_q.size() > 0)
      begin
         nm = chk_name_q.pop_front();
         e  = chk_exp_q.pop_front();
         a  = chk_act_q.pop_front();
         t  = chk_time_q.pop_front();
         assert (a == e)
         else
            abort_run($sformatf("ERROR: time %0t, %s, expected 'h%0h, actual 'h%0h",
                                t, nm, e, a));
      end
   end

   initial
   begin
      #(WATCHDOG_NS);
      abort_run("Timeout, the tests did not finish in the expected time");
   end

   // ******************************
   // Stimulus
   // ******************************
   initial
   begin
      logic [7:0] rd;
      void'($urandom(32'h45bebfd4));
      ireset  = 1'b0;
      adr     = '0;
      dbus_in = '0;
      iore    = 1'b0;
      iowe    = 1'b0;
      misoi   = 1'b0;
      spiack  = 1'b0;
      xfer_on = 1'b0;
      repeat (5) @(posedge cp2);
      #1;
      ireset  = 1'b1;

      check_val("scko", 0, scko);
      check_val("mosio", 0, mosio);
      check_val("spiirq", 0, spiirq);
      check_val("spe", 0, spe);
      check_val("spimaster", 0, spimaster);
      check_val("out_en idle", 0, out_en);
      bus_read(spi_pkg::SPCR_ADDR, rd);
      check_val("SPCR reset", 0, rd);
      bus_read(spi_pkg::SPSR_ADDR, rd);
      check_val("SPSR reset", 0, rd);
      bus_read(spi_pkg::SPDR_ADDR, rd);
      check_val("SPDR reset", 0, rd);

      // Each CPOL/CPHA/DORD mode paired with one of the eight rates
      for (int m = 0; m < 8; m++)
         for (int b = 0; b < 2; b++)
            run_transfer(3'(m), 3'(m), (b == 1), 8'($urandom), 1'b0, 1'b0);

      run_transfer(3'b000, 3'b100, 1'b1, 8'($urandom), 1'b0, 1'b1);
      run_transfer(3'b011, 3'b001, 1'b1, 8'($urandom), 1'b1, 1'b0);

      @(negedge cp2);
      @(negedge cp2);
      if (i_spi_mod.i_spi_mod_asserts.fail_cnt == 0)
      begin
         $display("Simulation completed successfully");
         $finish;
      end
      else
         abort_run("Bound SPI assertions reported failures");
   end

endmodule

/* spi_mod.f */
hw/spi_pkg.sv
hw/spi_ctrl_if.sv
hw/spi_regs.sv
hw/spi_clk_gen.sv
hw/spi_shifter.sv
hw/spi_mod.sv
sim/spi_mod_asserts.sv
sim/tb_spi_mod.sv
